// File: src/ising_cfg_pkg.sv
////////////////////////////////////////////////////////////////////////////
// array geometry of the Ising core and the payload types built from it
////////////////////////////////////////////////////////////////////////////

package ising_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int NUM_SPIN        = 16;       // spins in the analog array
    localparam int BIT_J           = 4;        // bits per coupling weight
    localparam int NUM_J_ROWS      = NUM_SPIN; // one J row per spin
    localparam int FLIP_ICON_DEPTH = 8;        // entries in flip memory

    ////////////////////////////////////////////////////////////////////////////
    // payloads and indices
    ////////////////////////////////////////////////////////////////////////////

    // one full row of couplings, weight 0 in the low bits
    typedef logic [NUM_SPIN*BIT_J-1:0] j_row_t;

    // spin mask, a set bit toggles that spin
    typedef logic [NUM_SPIN-1:0] flip_icon_t;

    typedef logic [NUM_SPIN-1:0] spin_vec_t;

    typedef logic [$clog2(NUM_J_ROWS)-1:0] j_idx_t;

    typedef logic [$clog2(FLIP_ICON_DEPTH)-1:0] icon_idx_t;

    // needs one extra code so that a full memory can be counted
    typedef logic [$clog2(FLIP_ICON_DEPTH+1)-1:0] icon_cnt_t;

endpackage

// File: src/ising_map_pkg.sv
////////////////////////////////////////////////////////////////////////////
// host address map for the J and flip memories
////////////////////////////////////////////////////////////////////////////

package ising_map_pkg;

    localparam int HOST_ADDR_W = 8;
    localparam int HOST_DATA_W = 64; // wide enough for a whole J row

    typedef logic [HOST_ADDR_W-1:0] host_addr_t;

    ////////////////////////////////////////////////////////////////////////////
    // regions, each one from its base up to the next base
    ////////////////////////////////////////////////////////////////////////////

    localparam host_addr_t J_MEM_BASE    = 8'h00; // 16 rows, 0x00 to 0x0f
    localparam host_addr_t FLIP_MEM_BASE = 8'h10; // 8 icons, 0x10 to 0x17
    localparam host_addr_t FLIP_MEM_END  = 8'h18; // everything from here is unmapped

endpackage

// File: src/l1_mem.sv
////////////////////////////////////////////////////////////////////////////
// L1 memory with one write port and one registered read port
////////////////////////////////////////////////////////////////////////////

module l1_mem #(
    parameter type data_t = logic,
    parameter int  DEPTH  = 16
) (
    input  logic                     clk_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  data_t                    wdata_i,
    input  logic                     re_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    output data_t                    rdata_o
);

    data_t mem_q [DEPTH];
    data_t rdata_q;

    // write port
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // read port, holds the last word while re_i is low
    // a write to the same entry at the same edge is seen one read later
    always_ff @(posedge clk_i) begin
        if (re_i) begin
            rdata_q <= mem_q[raddr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

// File: src/host_write_decode.sv
////////////////////////////////////////////////////////////////////////////
// host write strobe decoder for J and flip memories, with unmapped flag
////////////////////////////////////////////////////////////////////////////

module host_write_decode (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     host_we_i,
    input  ising_map_pkg::host_addr_t host_addr_i,
    output logic                     j_we_o,
    output ising_cfg_pkg::j_idx_t    j_waddr_o,
    output logic                     flip_we_o,
    output ising_cfg_pkg::icon_idx_t flip_waddr_o,
    output logic                     host_err_o
);

    logic                      hit_j;
    logic                      hit_flip;
    ising_map_pkg::host_addr_t j_off;
    ising_map_pkg::host_addr_t flip_off;
    logic                      err_q;

    ////////////////////////////////////////////////////////////////////////////
    // region match
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        hit_j    = (host_addr_i >= ising_map_pkg::J_MEM_BASE) &&
                   (host_addr_i <  ising_map_pkg::FLIP_MEM_BASE);
        hit_flip = (host_addr_i >= ising_map_pkg::FLIP_MEM_BASE) &&
                   (host_addr_i <  ising_map_pkg::FLIP_MEM_END);

        j_off    = host_addr_i - ising_map_pkg::J_MEM_BASE;    // row inside J region
        flip_off = host_addr_i - ising_map_pkg::FLIP_MEM_BASE; // icon inside flip region
    end

    assign j_we_o       = host_we_i & hit_j;
    assign j_waddr_o    = ising_cfg_pkg::j_idx_t'(j_off);
    assign flip_we_o    = host_we_i & hit_flip;
    assign flip_waddr_o = ising_cfg_pkg::icon_idx_t'(flip_off);

    // a write that lands in no region gives a single error pulse
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= host_we_i & ~hit_j & ~hit_flip;
        end
    end

    assign host_err_o = err_q;

endmodule

// File: src/weight_loader.sv
////////////////////////////////////////////////////////////////////////////
// weight loader, streams J rows onto the write word lines and bit lines
////////////////////////////////////////////////////////////////////////////

module weight_loader (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     load_start_i,
    input  ising_cfg_pkg::j_row_t    j_rdata_i,
    output logic                     j_re_o,
    output ising_cfg_pkg::j_idx_t    j_raddr_o,
    output logic                     load_busy_o,
    output ising_cfg_pkg::spin_vec_t j_wwl_o,
    output ising_cfg_pkg::j_row_t    wbl_o
);

    logic                     start_acc;
    logic                     run_q;     // read issue in progress
    ising_cfg_pkg::j_idx_t    row_q;     // row being read
    logic                     ret_q;     // row data is on j_rdata_i
    ising_cfg_pkg::j_idx_t    ret_row_q;
    ising_cfg_pkg::spin_vec_t wwl_q;
    ising_cfg_pkg::j_row_t    wbl_q;

    assign start_acc = load_start_i & ~load_busy_o; // no restart mid-sequence

    ////////////////////////////////////////////////////////////////////////////
    // read issue, one row per cycle
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            run_q <= 1'b0;
            row_q <= '0;
        end else if (start_acc) begin
            run_q <= 1'b1;
            row_q <= '0;
        end else if (run_q) begin
            row_q <= row_q + 1'b1;
            if (row_q == ising_cfg_pkg::j_idx_t'(ising_cfg_pkg::NUM_J_ROWS - 1)) begin
                run_q <= 1'b0; // last row issued
            end
        end
    end

    assign j_re_o    = run_q;
    assign j_raddr_o = row_q;

    ////////////////////////////////////////////////////////////////////////////
    // return and present
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ret_q <= 1'b0;
        end else begin
            ret_q <= run_q;
        end
    end

    always_ff @(posedge clk_i) begin
        ret_row_q <= row_q; // only looked at while ret_q is set
    end

    // word line is one-hot on the row whose bits sit on wbl
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wwl_q <= '0;
        end else if (ret_q) begin
            wwl_q <= ising_cfg_pkg::spin_vec_t'(1'b1) << ret_row_q;
        end else begin
            wwl_q <= '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ret_q) begin
            wbl_q <= j_rdata_i;
        end
    end

    assign j_wwl_o     = wwl_q;
    assign wbl_o       = wbl_q;
    assign load_busy_o = run_q | ret_q | (|wwl_q); // busy until the last row is off

endmodule

// File: src/flip_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// flip sequencer, reads flip icons in order and toggles the spin register
////////////////////////////////////////////////////////////////////////////

module flip_sequencer (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     cmpt_start_i,
    input  ising_cfg_pkg::icon_cnt_t icon_count_i,
    input  ising_cfg_pkg::flip_icon_t flip_rdata_i,
    output logic                     flip_re_o,
    output ising_cfg_pkg::icon_idx_t flip_raddr_o,
    output logic                     cmpt_idle_o,
    output ising_cfg_pkg::spin_vec_t spins_o
);

    logic                     start_acc;
    logic                     run_q;
    ising_cfg_pkg::icon_cnt_t addr_q;   // next icon to read
    ising_cfg_pkg::icon_cnt_t addr_nxt;
    ising_cfg_pkg::icon_cnt_t cnt_q;    // icons in this run
    logic                     rv_q;     // icon data valid on flip_rdata_i
    ising_cfg_pkg::spin_vec_t spins_q;

    assign start_acc = cmpt_start_i & cmpt_idle_o;
    assign addr_nxt  = addr_q + 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // icon read stepping
    ////////////////////////////////////////////////////////////////////////////

    // a zero count still takes one running cycle, then drops back to idle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            run_q  <= 1'b0;
            addr_q <= '0;
            cnt_q  <= '0;
        end else if (start_acc) begin
            run_q  <= 1'b1;
            addr_q <= '0;
            cnt_q  <= icon_count_i;
        end else if (run_q) begin
            addr_q <= addr_nxt;
            if ((cnt_q == '0) || (addr_nxt == cnt_q)) begin
                run_q <= 1'b0;
            end
        end
    end

    assign flip_re_o    = run_q & (cnt_q != '0);
    assign flip_raddr_o = ising_cfg_pkg::icon_idx_t'(addr_q); // addr_q stays below the count

    ////////////////////////////////////////////////////////////////////////////
    // spin update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rv_q <= 1'b0;
        end else begin
            rv_q <= flip_re_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            spins_q <= '0;
        end else if (rv_q) begin
            spins_q <= spins_q ^ flip_rdata_i; // one icon per cycle
        end
    end

    assign spins_o     = spins_q;
    assign cmpt_idle_o = ~run_q & ~rv_q; // idle only once the last icon has landed

endmodule

// File: src/ising_core_top.sv
////////////////////////////////////////////////////////////////////////////
// Ising core top, host decoder, J and flip memories, loader and sequencer
////////////////////////////////////////////////////////////////////////////

module ising_core_top (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                host_we_i,
    input  ising_map_pkg::host_addr_t           host_addr_i,
    input  logic [ising_map_pkg::HOST_DATA_W-1:0] host_wdata_i,
    input  logic                                load_start_i,
    input  logic                                cmpt_start_i,
    input  ising_cfg_pkg::icon_cnt_t            icon_count_i,
    output logic                                host_err_o,
    output ising_cfg_pkg::spin_vec_t            j_wwl_o,
    output ising_cfg_pkg::j_row_t               wbl_o,
    output logic                                load_busy_o,
    output logic                                cmpt_idle_o,
    output ising_cfg_pkg::spin_vec_t            spins_o
);

    logic                      j_we;
    ising_cfg_pkg::j_idx_t     j_waddr;
    logic                      j_re;
    ising_cfg_pkg::j_idx_t     j_raddr;
    ising_cfg_pkg::j_row_t     j_rdata;
    logic                      flip_we;
    ising_cfg_pkg::icon_idx_t  flip_waddr;
    logic                      flip_re;
    ising_cfg_pkg::icon_idx_t  flip_raddr;
    ising_cfg_pkg::flip_icon_t flip_rdata;

    ////////////////////////////////////////////////////////////////////////////
    // host write path
    ////////////////////////////////////////////////////////////////////////////

    host_write_decode u_decode (
        .clk_i        (clk_i       ),
        .rst_n_i      (rst_n_i     ),
        .host_we_i    (host_we_i   ),
        .host_addr_i  (host_addr_i ),
        .j_we_o       (j_we        ),
        .j_waddr_o    (j_waddr     ),
        .flip_we_o    (flip_we     ),
        .flip_waddr_o (flip_waddr  ),
        .host_err_o   (host_err_o  )
    );

    l1_mem #(
        .data_t (ising_cfg_pkg::j_row_t    ),
        .DEPTH  (ising_cfg_pkg::NUM_J_ROWS )
    ) u_l1_mem_j (
        .clk_i   (clk_i        ),
        .we_i    (j_we         ),
        .waddr_i (j_waddr      ),
        .wdata_i (host_wdata_i ), // full row per host write
        .re_i    (j_re         ),
        .raddr_i (j_raddr      ),
        .rdata_o (j_rdata      )
    );

    l1_mem #(
        .data_t (ising_cfg_pkg::flip_icon_t     ),
        .DEPTH  (ising_cfg_pkg::FLIP_ICON_DEPTH )
    ) u_l1_mem_flip (
        .clk_i   (clk_i                                   ),
        .we_i    (flip_we                                 ),
        .waddr_i (flip_waddr                              ),
        .wdata_i (host_wdata_i[ising_cfg_pkg::NUM_SPIN-1:0]), // icon is the low bits
        .re_i    (flip_re                                 ),
        .raddr_i (flip_raddr                              ),
        .rdata_o (flip_rdata                              )
    );

    ////////////////////////////////////////////////////////////////////////////
    // load and compute
    ////////////////////////////////////////////////////////////////////////////

    weight_loader u_weight_loader (
        .clk_i        (clk_i        ),
        .rst_n_i      (rst_n_i      ),
        .load_start_i (load_start_i ),
        .j_rdata_i    (j_rdata      ),
        .j_re_o       (j_re         ),
        .j_raddr_o    (j_raddr      ),
        .load_busy_o  (load_busy_o  ),
        .j_wwl_o      (j_wwl_o      ),
        .wbl_o        (wbl_o        )
    );

    flip_sequencer u_flip_sequencer (
        .clk_i        (clk_i        ),
        .rst_n_i      (rst_n_i      ),
        .cmpt_start_i (cmpt_start_i ),
        .icon_count_i (icon_count_i ),
        .flip_rdata_i (flip_rdata   ),
        .flip_re_o    (flip_re      ),
        .flip_raddr_o (flip_raddr   ),
        .cmpt_idle_o  (cmpt_idle_o  ),
        .spins_o      (spins_o      )
    );

endmodule

// File: include/tb_lfsr.svh
////////////////////////////////////////////////////////////////////////////
// Galois LFSR step for random testbench data
////////////////////////////////////////////////////////////////////////////

`ifndef TB_LFSR_SVH
`define TB_LFSR_SVH

// taps 32, 22, 2, 1 give a maximal length sequence
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
        nxt = nxt ^ 32'h8020_0003;
    end
    return nxt;
endfunction

// the bit a caller takes before stepping
function automatic logic lfsr_bit(input logic [31:0] state);
    return state[0];
endfunction

`endif

// File: tests/ising_core_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the Ising core top with shadow memories and a spin model
////////////////////////////////////////////////////////////////////////////

module ising_core_tb;

    `include "tb_lfsr.svh"

    // reset, J writes, three loads, unmapped writes, flip writes, two compute runs
    localparam int PHASE_CYCLES = 5 + 3*16 + 3*22 + 3*3 + 3*8 + 2*12;
    localparam int MAX_CYCLES   = 4 * PHASE_CYCLES;

    logic        clk;
    logic        rst_n;
    logic        host_we;
    logic [7:0]  host_addr;
    logic [63:0] host_wdata;
    logic        load_start;
    logic        cmpt_start;
    logic [3:0]  icon_count;
    logic        host_err;
    logic [15:0] j_wwl;
    logic [63:0] wbl;
    logic        load_busy;
    logic        cmpt_idle;
    logic [15:0] spins;

    logic [63:0] j_shadow [16];
    logic [15:0] flip_shadow [8];
    logic [15:0] spin_shadow = '0;
    logic [31:0] lfsr_state  = 32'hcf2f;
    logic [63:0] data;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    ising_core_top uut (
        .clk_i        (clk        ),
        .rst_n_i      (rst_n      ),
        .host_we_i    (host_we    ),
        .host_addr_i  (host_addr  ),
        .host_wdata_i (host_wdata ),
        .load_start_i (load_start ),
        .cmpt_start_i (cmpt_start ),
        .icon_count_i (icon_count ),
        .host_err_o   (host_err   ),
        .j_wwl_o      (j_wwl      ),
        .wbl_o        (wbl        ),
        .load_busy_o  (load_busy  ),
        .cmpt_idle_o  (cmpt_idle  ),
        .spins_o      (spins      )
    );

    always #20 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic random_bits(input int nbits, output logic [63:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            val[i]     = lfsr_bit(lfsr_state);
            lfsr_state = lfsr_next(lfsr_state); // one step per bit
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // one strobe with the error flag checked over the next two cycles
    task automatic host_write(input logic [7:0] addr, input logic [63:0] wdata);
        logic unmapped;
        unmapped = (addr >= ising_map_pkg::FLIP_MEM_END);
        @(posedge clk);
        host_we    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= wdata;
        @(posedge clk);
        host_we <= 1'b0;
        if (addr < ising_map_pkg::FLIP_MEM_BASE) begin
            j_shadow[addr - ising_map_pkg::J_MEM_BASE] = wdata;
        end else if (!unmapped) begin
            flip_shadow[addr - ising_map_pkg::FLIP_MEM_BASE] = wdata[15:0]; // low bits only
        end
        @(negedge clk);
        check_value("host_err_o", unmapped, host_err);
        @(negedge clk);
        check_value("host_err_o", 1'b0, host_err);
    endtask

    task automatic run_load(input bit extra_pulse);
        logic [63:0] one_hot;
        int          r;
        @(posedge clk);
        load_start <= 1'b1;
        @(posedge clk); // start edge
        load_start <= 1'b0;
        @(negedge clk);
        check_value("load_busy_o", 1'b1, load_busy);
        @(posedge clk);
        for (r = 0; r < ising_cfg_pkg::NUM_J_ROWS; r++) begin
            @(posedge clk);
            load_start <= extra_pulse && (r == 5); // pulse while busy
            @(negedge clk);
            one_hot = 64'd1 << r;
            check_value("j_wwl_o", one_hot, j_wwl);
            check_value("wbl_o", j_shadow[r], wbl);
            check_value("load_busy_o", 1'b1, load_busy);
        end
        @(posedge clk);
        @(negedge clk);
        check_value("load_busy_o", 1'b0, load_busy);
        check_value("j_wwl_o", 64'd0, j_wwl); // no seventeenth row
    endtask

    task automatic run_compute(input logic [3:0] count);
        logic [15:0] expect_spins;
        int          wait_cycles;
        expect_spins = spin_shadow;
        for (int i = 0; i < count; i++) begin
            expect_spins = expect_spins ^ flip_shadow[i];
        end
        check_value("cmpt_idle_o", 1'b1, cmpt_idle);
        @(posedge clk);
        cmpt_start <= 1'b1;
        icon_count <= count;
        @(posedge clk);
        cmpt_start <= 1'b0;
        @(negedge clk);
        check_value("cmpt_idle_o", 1'b0, cmpt_idle);
        wait_cycles = 0;
        while (!cmpt_idle && wait_cycles < 20) begin
            @(negedge clk);
            wait_cycles++;
        end
        checks++;
        assert (cmpt_idle) else begin
            errors++;
            $display("compute run of %0d icons never returned to idle", count);
        end
        check_value("spins_o", expect_spins, spins);
        spin_shadow = expect_spins;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        load_start = 1'b0;
        cmpt_start = 1'b0;
        icon_count = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("j_wwl_o", 64'd0, j_wwl);
        check_value("load_busy_o", 1'b0, load_busy);
        check_value("host_err_o", 1'b0, host_err);
        check_value("cmpt_idle_o", 1'b1, cmpt_idle);
        check_value("spins_o", 64'd0, spins);

        for (int a = 0; a < 16; a++) begin
            random_bits(64, data);
            host_write(ising_map_pkg::J_MEM_BASE + a, data);
        end
        run_load(1'b0);

        repeat (3) begin
            random_bits(8, data);
            host_write(ising_map_pkg::FLIP_MEM_END + data[7:0] % 232, data); // 0x18 to 0xff
        end
        run_load(1'b0); // rows must be untouched

        for (int a = 0; a < 8; a++) begin
            random_bits(64, data);
            host_write(ising_map_pkg::FLIP_MEM_BASE + a, data);
        end
        random_bits(3, data);
        run_compute(data[2:0] + 4'd1);
        run_compute(4'd0);
        run_load(1'b1);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
src/ising_cfg_pkg.sv
src/ising_map_pkg.sv
src/l1_mem.sv
src/host_write_decode.sv
src/weight_loader.sv
src/flip_sequencer.sv
src/ising_core_top.sv
tests/ising_core_tb.sv
